// ==== verilog/config_pkg.sv ====
package config_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address and instruction geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned PLEN = 32;  // Physical address width in bits.
  localparam int unsigned ILEN = 32;  // Instruction width in bits.

  localparam int unsigned INSTR_BYTES = ILEN / 8;  // Bytes per instruction.

  // Word aligned instructions leave the two low PC bits constant.
  localparam int unsigned INSTR_ADDR_LSB = $clog2(INSTR_BYTES);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch group shape
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned INSTR_PER_FETCH = 2;  // Slots predicted per fetch cycle.

  typedef logic [PLEN-1:0] pc_t;

endpackage

// ==== verilog/bp_pkg.sv ====
package bp_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // History and table sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned GHR_BITS = 8;
  typedef logic [GHR_BITS-1:0] ghr_t;

  localparam int unsigned SC_ENTRIES  = 512;
  localparam int unsigned SC_IDX_W    = 9;
  localparam int unsigned SC_CTR_BITS = 4;
  localparam int unsigned SC_PC_SALT   = 3;  // Salt of the PC fold in the SC index.
  localparam int unsigned SC_HIST_SALT = 5;  // Salt of the history fold.
  typedef logic [SC_IDX_W-1:0] sc_idx_t;
  typedef logic signed [SC_CTR_BITS-1:0] sc_ctr_t;

  localparam sc_ctr_t SC_MAX    = sc_ctr_t'(7);
  localparam sc_ctr_t SC_MIN    = sc_ctr_t'(-8);
  localparam sc_ctr_t SC_THRESH = sc_ctr_t'(3);  // Magnitude at which SC is trusted.

  localparam int unsigned BHT_ENTRIES = 256;
  localparam int unsigned BHT_IDX_W   = 8;
  typedef logic [BHT_IDX_W-1:0] bht_idx_t;
  typedef logic [1:0] bht_ctr_t;

  localparam bht_ctr_t BHT_MAX  = 2'd3;
  localparam bht_ctr_t BHT_MIN  = 2'd0;
  localparam bht_ctr_t BHT_INIT = 2'b01;  // Weakly not taken.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Interface structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [config_pkg::INSTR_PER_FETCH-1:0] slot_bits_t;

  typedef struct packed {
    logic              valid;
    config_pkg::pc_t   base_pc;
  } bp_req_t;

  typedef struct packed {
    logic       valid;
    slot_bits_t taken;
    slot_bits_t sc_used;
    ghr_t       ghr;
  } bp_rsp_t;

  typedef struct packed {
    logic            valid;
    config_pkg::pc_t pc;
    ghr_t            ghr;  // History echoed back from the prediction.
    logic            taken;
  } bp_update_t;

  typedef struct packed {
    slot_bits_t taken;
    slot_bits_t confident;
  } sc_pred_t;

  // Address of the given slot within a fetch group.
  function automatic config_pkg::pc_t slot_pc(input config_pkg::pc_t base_pc,
                                              input int unsigned slot);
    slot_pc = base_pc + config_pkg::pc_t'(config_pkg::INSTR_BYTES * slot);
  endfunction

endpackage

// ==== verilog/base_bht.sv ====
`timescale 1ns/1ps

module base_bht (
  input  logic               clk_i,
  input  logic               rst_i,
  input  bp_pkg::bp_req_t    req_i,
  input  bp_pkg::bp_update_t update_i,
  output bp_pkg::slot_bits_t taken_o
);

  config_pkg::pc_t  rd_pc   [config_pkg::INSTR_PER_FETCH];
  bp_pkg::bht_idx_t rd_idx  [config_pkg::INSTR_PER_FETCH];
  bp_pkg::bht_idx_t upd_idx;
  bp_pkg::bht_ctr_t upd_ctr;
  bp_pkg::bht_ctr_t ctr_q   [bp_pkg::BHT_ENTRIES];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int s = 0; s < config_pkg::INSTR_PER_FETCH; s++) begin
      rd_pc[s]   = bp_pkg::slot_pc(req_i.base_pc, s);
      rd_idx[s]  = rd_pc[s][config_pkg::INSTR_ADDR_LSB +: bp_pkg::BHT_IDX_W];
      taken_o[s] = ctr_q[rd_idx[s]][1];  // Upper half of the range means taken.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Training
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign upd_idx = update_i.pc[config_pkg::INSTR_ADDR_LSB +: bp_pkg::BHT_IDX_W];

  always_comb begin
    upd_ctr = ctr_q[upd_idx];
    if (update_i.taken) begin
      if (upd_ctr != bp_pkg::BHT_MAX) begin
        upd_ctr = upd_ctr + 2'd1;
      end
    end else begin
      if (upd_ctr != bp_pkg::BHT_MIN) begin
        upd_ctr = upd_ctr - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int e = 0; e < bp_pkg::BHT_ENTRIES; e++) begin
        ctr_q[e] <= bp_pkg::BHT_INIT;
      end
    end else if (update_i.valid) begin
      ctr_q[upd_idx] <= upd_ctr;  // Same cycle lookups still see the old value.
    end
  end

endmodule

// ==== verilog/sc_l.sv ====
`timescale 1ns/1ps

module sc_l (
  input  logic               clk_i,
  input  logic               rst_i,
  input  bp_pkg::bp_req_t    req_i,
  input  bp_pkg::ghr_t       ghr_i,
  output bp_pkg::sc_pred_t   pred_o,
  input  bp_pkg::bp_update_t update_i
);

  config_pkg::pc_t rd_pc  [config_pkg::INSTR_PER_FETCH];
  bp_pkg::sc_idx_t rd_idx [config_pkg::INSTR_PER_FETCH];
  bp_pkg::sc_ctr_t rd_ctr [config_pkg::INSTR_PER_FETCH];
  bp_pkg::sc_idx_t upd_idx;
  bp_pkg::sc_ctr_t upd_ctr;
  bp_pkg::sc_ctr_t ctr_q  [bp_pkg::SC_ENTRIES];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Index hashing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic bp_pkg::sc_idx_t fold_pc_idx(input config_pkg::pc_t pc,
                                                  input int unsigned salt);
    bp_pkg::sc_idx_t out_v;
    out_v = bp_pkg::sc_idx_t'(salt * 9);
    for (int i = config_pkg::INSTR_ADDR_LSB; i < config_pkg::PLEN; i++) begin
      out_v[(i + salt) % bp_pkg::SC_IDX_W] ^= pc[i];
    end
    return out_v;
  endfunction

  function automatic bp_pkg::sc_idx_t fold_hist_idx(input bp_pkg::ghr_t hist,
                                                    input int unsigned salt);
    bp_pkg::sc_idx_t out_v;
    out_v = bp_pkg::sc_idx_t'(salt * 13);
    for (int i = 0; i < bp_pkg::GHR_BITS; i++) begin
      out_v[(i + salt) % bp_pkg::SC_IDX_W] ^= hist[i];
    end
    return out_v;
  endfunction

  function automatic bp_pkg::sc_idx_t sc_index(input config_pkg::pc_t pc,
                                               input bp_pkg::ghr_t hist);
    return fold_pc_idx(pc, bp_pkg::SC_PC_SALT) ^ fold_hist_idx(hist, bp_pkg::SC_HIST_SALT);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Prediction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int s = 0; s < config_pkg::INSTR_PER_FETCH; s++) begin
      rd_pc[s]  = bp_pkg::slot_pc(req_i.base_pc, s);
      rd_idx[s] = sc_index(rd_pc[s], ghr_i);
      rd_ctr[s] = ctr_q[rd_idx[s]];

      pred_o.taken[s]     = (rd_ctr[s] >= bp_pkg::sc_ctr_t'(0));
      pred_o.confident[s] = (rd_ctr[s] >= bp_pkg::SC_THRESH) ||
                            (rd_ctr[s] <= -bp_pkg::SC_THRESH);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Training
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The echoed history selects the entry that made the prediction.
  assign upd_idx = sc_index(update_i.pc, update_i.ghr);

  always_comb begin
    upd_ctr = ctr_q[upd_idx];
    if (update_i.taken) begin
      if (upd_ctr != bp_pkg::SC_MAX) begin
        upd_ctr = upd_ctr + bp_pkg::sc_ctr_t'(1);
      end
    end else begin
      if (upd_ctr != bp_pkg::SC_MIN) begin
        upd_ctr = upd_ctr - bp_pkg::sc_ctr_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int e = 0; e < bp_pkg::SC_ENTRIES; e++) begin
        ctr_q[e] <= '0;
      end
    end else if (update_i.valid) begin
      ctr_q[upd_idx] <= upd_ctr;
    end
  end

endmodule

// ==== verilog/ghr_tracker.sv ====
`timescale 1ns/1ps

module ghr_tracker (
  input  logic               clk_i,
  input  logic               rst_i,
  input  bp_pkg::bp_update_t update_i,
  output bp_pkg::ghr_t       ghr_o
);

  bp_pkg::ghr_t ghr_q;
  bp_pkg::ghr_t ghr_d;

  // Oldest direction drops off the top, newest enters at bit 0.
  assign ghr_d = {ghr_q[bp_pkg::GHR_BITS-2:0], update_i.taken};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ghr_q <= '0;
    end else if (update_i.valid) begin
      ghr_q <= ghr_d;  // Only resolved branches shift the history.
    end
  end

  assign ghr_o = ghr_q;

endmodule

// ==== verilog/pred_select.sv ====
`timescale 1ns/1ps

module pred_select (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               req_valid_i,
  input  bp_pkg::slot_bits_t base_taken_i,
  input  bp_pkg::sc_pred_t   sc_pred_i,
  input  bp_pkg::ghr_t       ghr_i,
  output bp_pkg::bp_rsp_t    rsp_o
);

  bp_pkg::slot_bits_t sel_taken;
  bp_pkg::bp_rsp_t    rsp_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-slot selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int s = 0; s < config_pkg::INSTR_PER_FETCH; s++) begin
      if (sc_pred_i.confident[s]) begin
        sel_taken[s] = sc_pred_i.taken[s];  // Corrector overrides the bimodal guess.
      end else begin
        sel_taken[s] = base_taken_i[s];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q.valid   <= req_valid_i;
      rsp_q.sc_used <= req_valid_i ? sc_pred_i.confident : '0;  // Mask is clean when idle.
      if (req_valid_i) begin
        rsp_q.taken <= sel_taken;
        rsp_q.ghr   <= ghr_i;  // History used for the lookup, echoed back by the core.
      end
    end
  end

  assign rsp_o = rsp_q;

endmodule

// ==== verilog/bp_top.sv ====
`timescale 1ns/1ps

module bp_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  bp_pkg::bp_req_t    req_i,
  input  bp_pkg::bp_update_t update_i,
  output bp_pkg::bp_rsp_t    rsp_o
);

  bp_pkg::ghr_t       ghr;
  bp_pkg::slot_bits_t base_taken;
  bp_pkg::sc_pred_t   sc_pred;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // History
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  ghr_tracker ghr_tracker_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .update_i (update_i),
    .ghr_o    (ghr)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Direction tables
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  base_bht base_bht_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .update_i (update_i),
    .taken_o  (base_taken)
  );

  sc_l sc_l_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .ghr_i    (ghr),
    .pred_o   (sc_pred),
    .update_i (update_i)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Selection and response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  pred_select pred_select_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_i.valid),
    .base_taken_i (base_taken),
    .sc_pred_i    (sc_pred),
    .ghr_i        (ghr),
    .rsp_o        (rsp_o)
  );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD  = 10;  // 20 ns clock period.
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;  // Released on the same offset that the stimulus uses.
  end

endmodule

// ==== dv/bp_assertions.sv ====
`timescale 1ns/1ps

module bp_assertions (
  input logic            clk_i,
  input logic            rst_i,
  input bp_pkg::bp_req_t req_i,
  input bp_pkg::bp_rsp_t rsp_i
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response protocol
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  rsp_idle_in_reset: assert property (@(posedge clk_i) rst_i && $past(rst_i) |-> !rsp_i.valid)
    else $error("response valid is high while reset is held");

  rsp_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_i.valid |-> $past(req_i.valid))
    else $error("response valid without a request one cycle earlier");

  req_gets_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.valid |=> rsp_i.valid)
    else $error("request strobe not answered in the next cycle");

  // The mask only has meaning on a valid response.
  sc_used_idle: assert property (@(posedge clk_i) !rsp_i.valid |-> rsp_i.sc_used == '0)
    else $error("sc_used is set on an idle response");

endmodule

bind bp_top bp_assertions bp_assertions_i (
  .clk_i (clk_i),
  .rst_i (rst_i),
  .req_i (req_i),
  .rsp_i (rsp_o)
);

// ==== dv/bp_tb.sv ====
`timescale 1ns/1ps

module bp_tb;

  localparam int TIMEOUT_CYCLES = 4000;  // Well above the length of all tests together.
  localparam int RANDOM_CYCLES  = 300;

  logic               clk;
  logic               rst;
  bp_pkg::bp_req_t    req;
  bp_pkg::bp_update_t upd;
  bp_pkg::bp_rsp_t    rsp;

  // Reference model state.
  bp_pkg::bht_ctr_t bht_m [bp_pkg::BHT_ENTRIES];
  int               sc_m  [bp_pkg::SC_ENTRIES];
  bp_pkg::ghr_t     ghr_m;

  string cur_test;
  int    test_cnt;
  int    check_cnt;
  int    err_cnt;
  int    test_err_base;
  int    cycle_cnt;
  int    seed;

  tb_clock clock_gen_i (
    .clk_o (clk),
    .rst_o (rst)
  );

  bp_top dut_i (
    .clk_i    (clk),
    .rst_i    (rst),
    .req_i    (req),
    .update_i (upd),
    .rsp_o    (rsp)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Salted fold of bits [hi-1:lo] into a 9-bit index.
  function automatic bp_pkg::sc_idx_t hash_fold(input logic [31:0] bits, input int lo,
                                                input int hi, input int salt, input int mult);
    bp_pkg::sc_idx_t h;
    h = bp_pkg::sc_idx_t'(salt * mult);
    for (int i = lo; i < hi; i++) begin
      h[(i + salt) % 9] = h[(i + salt) % 9] ^ bits[i];
    end
    return h;
  endfunction

  function automatic bp_pkg::sc_idx_t model_sc_index(input config_pkg::pc_t pc,
                                                     input bp_pkg::ghr_t hist);
    return hash_fold(pc, 2, 32, 3, 9) ^ hash_fold({24'h0, hist}, 0, 8, 5, 13);
  endfunction

  function automatic bp_pkg::bp_rsp_t predict_model(input bp_pkg::bp_req_t r);
    bp_pkg::bp_rsp_t exp;
    config_pkg::pc_t pc;
    int              ctr;
    logic            conf;
    exp = '0;
    if (r.valid) begin
      exp.valid = 1'b1;
      exp.ghr   = ghr_m;
      for (int s = 0; s < config_pkg::INSTR_PER_FETCH; s++) begin
        pc   = r.base_pc + config_pkg::pc_t'(4 * s);
        ctr  = sc_m[model_sc_index(pc, ghr_m)];
        conf = (ctr >= 3) || (ctr <= -3);
        exp.sc_used[s] = conf;
        exp.taken[s]   = conf ? (ctr >= 0) : bht_m[pc[9:2]][1];
      end
    end
    return exp;
  endfunction

  task automatic train_model(input bp_pkg::bp_update_t u);
    bp_pkg::sc_idx_t si;
    logic [7:0]      bi;
    si = model_sc_index(u.pc, u.ghr);
    bi = u.pc[9:2];
    if (u.taken) begin
      if (bht_m[bi] != 2'd3) begin
        bht_m[bi] = bht_m[bi] + 2'd1;
      end
      if (sc_m[si] < 7) begin
        sc_m[si] = sc_m[si] + 1;
      end
    end else begin
      if (bht_m[bi] != 2'd0) begin
        bht_m[bi] = bht_m[bi] - 2'd1;
      end
      if (sc_m[si] > -8) begin
        sc_m[si] = sc_m[si] - 1;
      end
    end
    ghr_m = {ghr_m[6:0], u.taken};
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks and reporting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_rsp(input bp_pkg::bp_rsp_t exp, input bp_pkg::bp_rsp_t act);
    logic bad;
    check_cnt++;
    if (exp.valid) begin
      bad = (act !== exp);
    end else begin
      bad = (act.valid !== 1'b0) || (act.sc_used !== '0);  // Idle fields hold old data.
    end
    if (bad) begin
      err_cnt++;
      $display("error: %s response expected %h actual %h", cur_test, exp, act);
    end
  endtask

  task automatic check_ghr(input bp_pkg::ghr_t exp, input bp_pkg::ghr_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("error: %s history expected %h actual %h", cur_test, exp, act);
    end
  endtask

  task automatic expect_slot0(input logic conf, input logic tk, input string what);
    check_cnt++;
    if (rsp.sc_used[0] !== conf || rsp.taken[0] !== tk) begin
      err_cnt++;
      $display("error: %s slot 0 expected sc_used %b taken %b actual sc_used %b taken %b, %s",
               cur_test, conf, tk, rsp.sc_used[0], rsp.taken[0], what);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    $display("test %-20s finished, %0d failed checks", cur_test, err_cnt - test_err_base);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Entered 1 ns after a rising edge and left at the same point one cycle later.
  task automatic run_cycle(input bp_pkg::bp_req_t r, input bp_pkg::bp_update_t u);
    bp_pkg::bp_rsp_t exp;
    req = r;
    upd = u;
    exp = predict_model(r);  // A same-cycle update is not yet visible.
    if (u.valid) begin
      train_model(u);
    end
    @(posedge clk);
    #1;
    check_rsp(exp, rsp);
  endtask

  task automatic send_request(input config_pkg::pc_t pc);
    bp_pkg::bp_req_t    r;
    bp_pkg::bp_update_t u;
    r         = '0;
    u         = '0;
    r.valid   = 1'b1;
    r.base_pc = pc;
    run_cycle(r, u);
  endtask

  task automatic send_update(input config_pkg::pc_t pc, input bp_pkg::ghr_t hist,
                             input logic taken);
    bp_pkg::bp_req_t    r;
    bp_pkg::bp_update_t u;
    r       = '0;
    u.valid = 1'b1;
    u.pc    = pc;
    u.ghr   = hist;
    u.taken = taken;
    run_cycle(r, u);
  endtask

  task automatic train_fixed(input config_pkg::pc_t pc, input bp_pkg::ghr_t hist,
                             input logic taken, input int n);
    for (int i = 0; i < n; i++) begin
      send_update(pc, hist, taken);
    end
  endtask

  // Shifts a whole history word in, oldest bit first.
  task automatic load_history(input bp_pkg::ghr_t hist);
    for (int b = 7; b >= 0; b--) begin
      send_update(32'h0000_0e00, 8'h00, hist[b]);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reset_state();
    bp_pkg::bp_rsp_t lit;
    begin_test("reset_state");
    send_request(32'h0000_0100);
    lit       = '0;
    lit.valid = 1'b1;
    check_rsp(lit, rsp);
    check_ghr(8'h00, rsp.ghr);
    end_test();
  endtask

  task automatic base_training();
    config_pkg::pc_t pc;
    begin_test("base_training");
    pc = 32'h0000_0240;
    for (int i = 0; i < 2; i++) begin
      send_update(pc, ghr_m, 1'b1);
    end
    send_request(pc);
    expect_slot0(1'b0, 1'b1, "two taken updates did not make the base table predict taken");
    for (int i = 0; i < 3; i++) begin
      send_update(pc, ghr_m, 1'b1);
    end
    send_update(pc, ghr_m, 1'b0);
    send_request(pc);
    expect_slot0(1'b0, 1'b1, "one not-taken update flipped a saturated base counter");
    end_test();
  endtask

  task automatic corrector_override();
    config_pkg::pc_t pc;
    bp_pkg::ghr_t    hist;
    bp_pkg::sc_idx_t idx;
    begin_test("corrector_override");
    pc   = 32'h0000_1230;
    hist = 8'h5a;
    idx  = model_sc_index(pc, hist);
    for (int n = 0; n < 16 && sc_m[idx] < 3; n++) begin
      send_update(pc, hist, 1'b1);
    end
    for (int n = 0; n < 4 && bht_m[pc[9:2]] != 2'd0; n++) begin
      send_update(pc, ~hist, 1'b0);  // Base table goes the other way under another history.
    end
    load_history(hist);
    send_request(pc);
    expect_slot0(1'b1, 1'b1, "confident corrector did not override the base prediction");
    end_test();
  endtask

  task automatic counter_saturation();
    config_pkg::pc_t pc;
    config_pkg::pc_t pc_fill;
    begin_test("counter_saturation");
    pc      = 32'h0000_0a10;
    pc_fill = 32'h0000_0c00;
    train_fixed(pc, 8'hff, 1'b1, 16);  // History ends at all ones.
    send_request(pc);
    expect_slot0(1'b1, 1'b1, "counter is not confident taken after a long taken run");
    train_fixed(pc, 8'hff, 1'b0, 5);
    train_fixed(pc_fill, 8'h00, 1'b1, 8);
    send_request(pc);
    expect_slot0(1'b0, 1'b0, "counter did not stop at +7 during the taken run");
    train_fixed(pc, 8'hff, 1'b0, 20);
    train_fixed(pc_fill, 8'h00, 1'b1, 8);
    send_request(pc);
    expect_slot0(1'b1, 1'b0, "counter is not confident not-taken after a long run");
    train_fixed(pc, 8'hff, 1'b1, 5);
    train_fixed(pc_fill, 8'h00, 1'b1, 8);
    send_request(pc);
    expect_slot0(1'b1, 1'b0, "counter did not stop at -8 during the not-taken run");
    end_test();
  endtask

  task automatic history_shift();
    config_pkg::pc_t    pc;
    bp_pkg::ghr_t       g0;
    logic [4:0]         pat;
    bp_pkg::bp_req_t    r;
    bp_pkg::bp_update_t u;
    begin_test("history_shift");
    pc  = 32'h0000_0380;
    g0  = ghr_m;
    pat = 5'b10110;
    for (int b = 4; b >= 0; b--) begin
      send_update(pc, ghr_m, pat[b]);
    end
    send_request(pc);
    check_ghr({g0[2:0], 5'b10110}, rsp.ghr);
    r         = '0;
    r.valid   = 1'b1;
    r.base_pc = pc;
    u.valid   = 1'b1;
    u.pc      = pc;
    u.ghr     = ghr_m;
    u.taken   = 1'b0;  // Drops the base counter from weakly taken to weakly not taken.
    run_cycle(r, u);
    check_ghr({g0[2:0], 5'b10110}, rsp.ghr);  // Request beside an update sees the old history.
    send_request(pc);
    check_ghr({g0[1:0], 6'b101100}, rsp.ghr);
    end_test();
  endtask

  task automatic random_mix();
    bp_pkg::bp_req_t    r;
    bp_pkg::bp_update_t u;
    int                 rv;
    begin_test("random_mix");
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      rv        = $random(seed);
      r.valid   = rv[0] | rv[1];  // Mostly back-to-back requests.
      r.base_pc = config_pkg::pc_t'(rv) & 32'h0000_0ffc;
      rv        = $random(seed);
      u.valid   = rv[0];
      u.taken   = rv[1];
      u.pc      = config_pkg::pc_t'(rv) & 32'h0000_0ffc;
      u.ghr     = rv[12] ? ghr_m : rv[31:24];
      run_cycle(r, u);
    end
    r = '0;
    u = '0;
    run_cycle(r, u);
    end_test();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Run control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    seed      = 32'h6a8b;
    req       = '0;
    upd       = '0;
    test_cnt  = 0;
    check_cnt = 0;
    err_cnt   = 0;
    cycle_cnt = 0;
    ghr_m     = '0;
    for (int e = 0; e < bp_pkg::BHT_ENTRIES; e++) begin
      bht_m[e] = 2'b01;
    end
    for (int e = 0; e < bp_pkg::SC_ENTRIES; e++) begin
      sc_m[e] = 0;
    end
    @(negedge rst);
    reset_state();
    base_training();
    corrector_override();
    counter_saturation();
    history_shift();
    random_mix();
    $display("summary: %0d tests, %0d checks, %0d failed", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/config_pkg.sv
verilog/bp_pkg.sv
verilog/base_bht.sv
verilog/sc_l.sv
verilog/ghr_tracker.sv
verilog/pred_select.sv
verilog/bp_top.sv
dv/tb_clock.sv
dv/bp_assertions.sv
dv/bp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module bp_tb \
  -f verilog.f -o bp_sim \
  && ./obj_dir/bp_sim 2>&1 | tee sim.log \
  && ! grep -q "ERRORS FOUND" sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
